//--- common/io_pkg.sv
`default_nettype none

package io_pkg;

  // Bus widths
  localparam int WORD_W = 16;
  localparam int ADDR_W = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] io_addr_t;

  // Counter widths, both split into bus words for access
  localparam int TICK_W  = 48;
  localparam int TIMER_W = 32;

  // Interrupt numbering
  // External requests sit on the lowest lines, timer on the top one
  localparam int NUM_INT   = 8;
  localparam int TIMER_INT = 7;

  // Interrupt controller
  localparam io_addr_t ADR_INT_FLAGS = 16'd40;
  localparam io_addr_t ADR_INT_MASK  = 16'd50;

  // Tick sample, low word first
  localparam io_addr_t ADR_TICKSS_L  = 16'd105;
  localparam io_addr_t ADR_TICKSS_H  = 16'd106;
  localparam io_addr_t ADR_TICKSS_HH = 16'd107;

  // Write-only, data ignored
  localparam io_addr_t ADR_TICK_SAMPLE = 16'd109;

  // Period timer reload value
  localparam io_addr_t ADR_TIMER_L = 16'd110;
  localparam io_addr_t ADR_TIMER_H = 16'd111;

  // General port
  localparam io_addr_t ADR_PORT_IN  = 16'd310;
  localparam io_addr_t ADR_PORT_OUT = 16'd311;
  localparam io_addr_t ADR_PORT_DIR = 16'd312;

endpackage

`default_nettype wire

//--- int_ctrl/edge_sync.sv
`timescale 1ns/100ps
`default_nettype none

module edge_sync #(
  parameter int NUM_EXT_INT = 4
) (
  input  logic                    clk,
  input  logic                    resetq,
  input  logic [NUM_EXT_INT-1:0]  pins,
  output logic [NUM_EXT_INT-1:0]  rise
);

  // Stage 1 and 2 resolve metastability, stage 3 is the previous value
  logic [NUM_EXT_INT-1:0] sync_1;
  logic [NUM_EXT_INT-1:0] sync_2;
  logic [NUM_EXT_INT-1:0] sync_3;

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      sync_1 <= '0;
      sync_2 <= '0;
      sync_3 <= '0;
    end
    else
    begin
      sync_1 <= pins;
      sync_2 <= sync_1;
      sync_3 <= sync_2;
    end
  end

  // One-cycle pulse per low-to-high transition
  assign rise = sync_2 & ~sync_3;

endmodule

`default_nettype wire

//--- int_ctrl/int_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module int_ctrl #(
  parameter int NUM_EXT_INT = 4
) (
  input  logic                       clk,
  input  logic                       resetq,
  input  io_pkg::word_t              io_wdata,
  input  logic                       wr_flags,
  input  logic                       wr_mask,
  input  logic [NUM_EXT_INT-1:0]     ext_rise,
  input  logic                       timer_expire,
  output io_pkg::word_t              int_flags,
  output io_pkg::word_t              int_mask,
  output logic [io_pkg::NUM_INT-1:0] int_rqst
);

  localparam int N = io_pkg::NUM_INT;

  logic [N-1:0] pending;
  logic [N-1:0] set_req;

  // Requests by line number
  // Lines between the external pins and the timer stay idle
  always_comb
  begin
    set_req = '0;
    set_req[NUM_EXT_INT-1:0] = ext_rise;
    set_req[io_pkg::TIMER_INT] = timer_expire;
  end

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      int_flags <= '1;
      int_mask  <= '0;
    end
    else
    begin
      if (wr_flags)
        int_flags <= io_wdata;
      if (wr_mask)
        int_mask <= io_wdata;
    end
  end

  // A 0 in a flag bit clears its pending bit on every edge
  // A new request on the same edge wins
  always_ff @(posedge clk)
  begin
    if (!resetq)
      pending <= '0;
    else
      pending <= set_req | (pending & int_flags[N-1:0]);
  end

  assign int_rqst = pending & int_mask[N-1:0];

  // A newly written mask takes hold on the very next cycle
  assert property (@(posedge clk) disable iff (!resetq)
    wr_mask |=> ((int_rqst & ~$past(io_wdata[N-1:0])) == '0))
    else $error("interrupt request outside enable mask");

endmodule

`default_nettype wire

//--- timers/tick_counter.sv
`timescale 1ns/100ps
`default_nettype none

module tick_counter (
  input  logic                       clk,
  input  logic                       resetq,
  input  logic                       wr_sample,
  output logic [io_pkg::TICK_W-1:0]  tick_sample
);

  logic [io_pkg::TICK_W-1:0] ticks;

  // Free-running, wraps after 2**48 cycles
  always_ff @(posedge clk)
  begin
    if (!resetq)
      ticks <= '0;
    else
      ticks <= ticks + 1'b1;
  end

  // Snapshot so software reads all three words from one instant
  // Captures the count from before the write edge
  always_ff @(posedge clk)
  begin
    if (!resetq)
      tick_sample <= '0;
    else if (wr_sample)
      tick_sample <= ticks;
  end

endmodule

`default_nettype wire

//--- timers/period_timer.sv
`timescale 1ns/100ps
`default_nettype none

module period_timer (
  input  logic           clk,
  input  logic           resetq,
  input  io_pkg::word_t  io_wdata,
  input  logic           wr_reload_lo,
  input  logic           wr_reload_hi,
  output logic           expire
);

  localparam int W = io_pkg::WORD_W;

  logic [io_pkg::TIMER_W-1:0] reload;
  logic [io_pkg::TIMER_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      reload <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_reload_lo)
        reload[W-1:0] <= io_wdata;
      // High word write restarts the period with the new value
      if (wr_reload_hi)
      begin
        reload[2*W-1:W] <= io_wdata;
        count <= {io_wdata, reload[W-1:0]};
      end
      // Clearing the whole reload value stops a running period at once
      else if (wr_reload_lo && (io_wdata == '0) && (reload[2*W-1:W] == '0))
        count <= '0;
      else if (count == 1)
        count <= reload;
      else if (count != '0)
        count <= count - 1'b1;
      // A count of 0 means stopped
    end
  end

  // Last cycle of the period
  assign expire = (count == 1);

  assert property (@(posedge clk) disable iff (!resetq)
    (reload == '0) |-> !expire)
    else $error("timer expired with zero reload value");

endmodule

`default_nettype wire

//--- rtl/io_decode.sv
`timescale 1ns/100ps
`default_nettype none

module io_decode (
  input  logic                       clk,
  input  logic                       resetq,
  input  io_pkg::io_addr_t           io_addr,
  input  logic                       io_wr,
  input  io_pkg::word_t              io_wdata,
  output logic                       wr_flags,
  output logic                       wr_mask,
  output logic                       wr_sample,
  output logic                       wr_reload_lo,
  output logic                       wr_reload_hi,
  input  io_pkg::word_t              int_flags,
  input  io_pkg::word_t              int_mask,
  input  logic [io_pkg::TICK_W-1:0]  tick_sample,
  input  io_pkg::word_t              port_in,
  output io_pkg::word_t              port_out,
  output io_pkg::word_t              port_oe,
  output io_pkg::word_t              io_rdata
);

  localparam int W = io_pkg::WORD_W;

  logic wr_port_out;
  logic wr_port_dir;

  // Write strobes, one per register
  assign wr_flags     = io_wr && (io_addr == io_pkg::ADR_INT_FLAGS);
  assign wr_mask      = io_wr && (io_addr == io_pkg::ADR_INT_MASK);
  assign wr_sample    = io_wr && (io_addr == io_pkg::ADR_TICK_SAMPLE);
  assign wr_reload_lo = io_wr && (io_addr == io_pkg::ADR_TIMER_L);
  assign wr_reload_hi = io_wr && (io_addr == io_pkg::ADR_TIMER_H);
  assign wr_port_out  = io_wr && (io_addr == io_pkg::ADR_PORT_OUT);
  assign wr_port_dir  = io_wr && (io_addr == io_pkg::ADR_PORT_DIR);

  // Port registers, a 1 in port_oe drives the pin
  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      port_out <= '0;
      port_oe  <= '0;
    end
    else
    begin
      if (wr_port_out)
        port_out <= io_wdata;
      if (wr_port_dir)
        port_oe <= io_wdata;
    end
  end

  // Read mux
  // Unselected sources contribute zero, so unmapped and write-only addresses read 0
  assign io_rdata =
    ((io_addr == io_pkg::ADR_INT_FLAGS) ? int_flags : '0) |
    ((io_addr == io_pkg::ADR_INT_MASK)  ? int_mask  : '0) |
    ((io_addr == io_pkg::ADR_PORT_IN)   ? port_in   : '0) |
    ((io_addr == io_pkg::ADR_PORT_OUT)  ? port_out  : '0) |
    ((io_addr == io_pkg::ADR_PORT_DIR)  ? port_oe   : '0) |
    ((io_addr == io_pkg::ADR_TICKSS_L)  ? tick_sample[W-1:0]   : '0) |
    ((io_addr == io_pkg::ADR_TICKSS_H)  ? tick_sample[2*W-1:W] : '0) |
    ((io_addr == io_pkg::ADR_TICKSS_HH) ? tick_sample[3*W-1:2*W] : '0);

  // The blocks downstream assume a single register is written per cycle
  assert property (@(posedge clk) disable iff (!resetq)
    $onehot0({wr_flags, wr_mask, wr_sample, wr_reload_lo, wr_reload_hi,
              wr_port_out, wr_port_dir}))
    else $error("more than one write strobe active");

endmodule

`default_nettype wire

//--- rtl/io_top.sv
`timescale 1ns/100ps
`default_nettype none

module io_top #(
  parameter int NUM_EXT_INT = 4
) (
  input  logic                        clk,
  input  logic                        resetq,
  input  io_pkg::io_addr_t            io_addr,
  input  logic                        io_wr,
  input  io_pkg::word_t               io_wdata,
  output io_pkg::word_t               io_rdata,
  input  logic [NUM_EXT_INT-1:0]      ext_int,
  input  io_pkg::word_t               port_in,
  output io_pkg::word_t               port_out,
  output io_pkg::word_t               port_oe,
  output logic [io_pkg::NUM_INT-1:0]  int_rqst
);

  logic wr_flags;
  logic wr_mask;
  logic wr_sample;
  logic wr_reload_lo;
  logic wr_reload_hi;

  io_pkg::word_t int_flags;
  io_pkg::word_t int_mask;

  logic [io_pkg::TICK_W-1:0] tick_sample;
  logic [NUM_EXT_INT-1:0]    ext_rise;
  logic                      timer_expire;

  io_decode u_decode (
    .clk          (clk),
    .resetq       (resetq),
    .io_addr      (io_addr),
    .io_wr        (io_wr),
    .io_wdata     (io_wdata),
    .wr_flags     (wr_flags),
    .wr_mask      (wr_mask),
    .wr_sample    (wr_sample),
    .wr_reload_lo (wr_reload_lo),
    .wr_reload_hi (wr_reload_hi),
    .int_flags    (int_flags),
    .int_mask     (int_mask),
    .tick_sample  (tick_sample),
    .port_in      (port_in),
    .port_out     (port_out),
    .port_oe      (port_oe),
    .io_rdata     (io_rdata)
  );

  edge_sync #(
    .NUM_EXT_INT (NUM_EXT_INT)
  ) u_edge_sync (
    .clk    (clk),
    .resetq (resetq),
    .pins   (ext_int),
    .rise   (ext_rise)
  );

  int_ctrl #(
    .NUM_EXT_INT (NUM_EXT_INT)
  ) u_int_ctrl (
    .clk          (clk),
    .resetq       (resetq),
    .io_wdata     (io_wdata),
    .wr_flags     (wr_flags),
    .wr_mask      (wr_mask),
    .ext_rise     (ext_rise),
    .timer_expire (timer_expire),
    .int_flags    (int_flags),
    .int_mask     (int_mask),
    .int_rqst     (int_rqst)
  );

  tick_counter u_tick_counter (
    .clk         (clk),
    .resetq      (resetq),
    .wr_sample   (wr_sample),
    .tick_sample (tick_sample)
  );

  period_timer u_period_timer (
    .clk          (clk),
    .resetq       (resetq),
    .io_wdata     (io_wdata),
    .wr_reload_lo (wr_reload_lo),
    .wr_reload_hi (wr_reload_hi),
    .expire       (timer_expire)
  );

endmodule

`default_nettype wire

//--- test/io_checker.sv
`timescale 1ns/100ps
`default_nettype none

module io_checker (
  input  logic                        clk,
  input  logic                        chk,
  input  logic [2:0]                  chk_sel,
  input  logic [47:0]                 chk_exp,
  input  logic [191:0]                chk_name,
  input  logic [47:0]                 measured,
  input  logic                        missed,
  input  logic                        done,
  input  io_pkg::word_t               io_rdata,
  input  logic [io_pkg::NUM_INT-1:0]  int_rqst,
  input  io_pkg::word_t               port_out,
  input  io_pkg::word_t               port_oe,
  output int                          errors
);

  localparam logic [2:0] SEL_RDATA = 3'd0;
  localparam logic [2:0] SEL_RQST  = 3'd1;
  localparam logic [2:0] SEL_OUT   = 3'd2;
  localparam logic [2:0] SEL_OE    = 3'd3;
  localparam logic [2:0] SEL_MEAS  = 3'd4;

  int checks;
  logic [47:0] actual;

  // Source picked by the stimulus for this check
  always_comb
  begin
    case (chk_sel)
      SEL_RDATA: actual = {32'd0, io_rdata};
      SEL_RQST:  actual = {40'd0, int_rqst};
      SEL_OUT:   actual = {32'd0, port_out};
      SEL_OE:    actual = {32'd0, port_oe};
      SEL_MEAS:  actual = measured;
      default:   actual = '0;
    endcase
  end

  initial
  begin
    errors = 0;
    checks = 0;
  end

  // Compare in mid-cycle, well away from the driving edge
  always @(negedge clk)
  begin
    if (chk)
    begin
      checks = checks + 1;
      if (actual !== chk_exp)
      begin
        errors = errors + 1;
        $display("Fail %0s: expected %h, actual %h", chk_name, chk_exp, actual);
      end
    end
    if (missed)
    begin
      errors = errors + 1;
      $display("Interrupt request %h never arrived in %0s", chk_exp[7:0], chk_name);
    end
    if (done)
      $display("Checks run: %0d, errors: %0d", checks, errors);
  end

endmodule

`default_nettype wire

//--- test/tb_io_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_io_top;

  localparam int OP_WR = 0, OP_RD = 1, OP_WAIT = 2, OP_PIN = 3, OP_WINT = 4;
  localparam int OP_RQ = 5, OP_OUT = 6, OP_TICK = 7, OP_PERIOD = 8;

  typedef struct {
    logic [191:0]      name;
    int                op;
    io_pkg::io_addr_t  addr;
    io_pkg::word_t     data;
    logic [47:0]       exp;
    int                cycles;
    bit                rnd;
  } step_t;

  logic clk = 1'b0;
  logic resetq;
  io_pkg::io_addr_t io_addr;
  logic io_wr;
  io_pkg::word_t io_wdata;
  io_pkg::word_t io_rdata;
  logic [3:0] ext_int;
  io_pkg::word_t port_in;
  io_pkg::word_t port_out;
  io_pkg::word_t port_oe;
  logic [io_pkg::NUM_INT-1:0] int_rqst;

  logic chk;
  logic [2:0] chk_sel;
  logic [47:0] chk_exp;
  logic [191:0] chk_name;
  logic [47:0] measured;
  logic missed;
  logic done;
  int errors;

  step_t steps[$];
  logic [31:0] lfsr = 32'h7203_c399;
  io_pkg::word_t rand_val [0:3];
  logic [47:0] sample_cyc [0:1];
  logic [47:0] tick_val;
  logic [47:0] rise_cyc [0:3];
  logic [47:0] cyc = '0;
  int limit = 0;

  always #10 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1'b1;

  io_top #(.NUM_EXT_INT(4)) UUT (
    .clk(clk), .resetq(resetq), .io_addr(io_addr), .io_wr(io_wr),
    .io_wdata(io_wdata), .io_rdata(io_rdata), .ext_int(ext_int),
    .port_in(port_in), .port_out(port_out), .port_oe(port_oe), .int_rqst(int_rqst)
  );

  io_checker u_checker (
    .clk(clk), .chk(chk), .chk_sel(chk_sel), .chk_exp(chk_exp), .chk_name(chk_name),
    .measured(measured), .missed(missed), .done(done), .io_rdata(io_rdata),
    .int_rqst(int_rqst), .port_out(port_out), .port_oe(port_oe), .errors(errors)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic get_rand(output io_pkg::word_t v);
    for (int i = 0; i < 16; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic add(input logic [191:0] nm, input int op, input io_pkg::io_addr_t a,
                     input io_pkg::word_t d, input logic [47:0] e, input int n,
                     input bit r);
    step_t s;
    s.name = nm;
    s.op = op;
    s.addr = a;
    s.data = d;
    s.exp = e;
    s.cycles = n;
    s.rnd = r;
    steps.push_back(s);
  endtask

  task automatic drive(input io_pkg::io_addr_t a, input logic w, input io_pkg::word_t d,
                       input logic c, input logic [2:0] sel, input logic [47:0] e,
                       input logic [47:0] m, input logic [191:0] nm);
    @(posedge clk);
    io_addr <= a;
    io_wr <= w;
    io_wdata <= d;
    chk <= c;
    chk_sel <= sel;
    chk_exp <= e;
    measured <= m;
    chk_name <= nm;
    missed <= 1'b0;
  endtask

  task automatic read_word(input io_pkg::io_addr_t a, output io_pkg::word_t v);
    drive(a, 1'b0, '0, 1'b0, 3'd0, '0, '0, '0);
    @(negedge clk);
    v = io_rdata;
  endtask

  task automatic build_table;
    // name, op, addr, data, expected or random slot, cycles, random
    add("reset flags", OP_RD, io_pkg::ADR_INT_FLAGS, 0, 48'hffff, 1, 0);
    add("reset mask", OP_RD, io_pkg::ADR_INT_MASK, 0, 0, 1, 0);
    add("reset port out", OP_RD, io_pkg::ADR_PORT_OUT, 0, 0, 1, 0);
    add("reset port dir", OP_RD, io_pkg::ADR_PORT_DIR, 0, 0, 1, 0);
    add("unmapped read", OP_RD, 16'd200, 0, 0, 1, 0);
    add("port out write", OP_WR, io_pkg::ADR_PORT_OUT, 0, 0, 1, 1);
    add("port dir write", OP_WR, io_pkg::ADR_PORT_DIR, 0, 1, 1, 1);
    add("port out read", OP_RD, io_pkg::ADR_PORT_OUT, 0, 0, 1, 1);
    add("port dir read", OP_RD, io_pkg::ADR_PORT_DIR, 0, 1, 1, 1);
    add("port out pins", OP_OUT, 0, 0, 0, 1, 1);
    add("port oe pins", OP_OUT, 1, 0, 1, 1, 1);
    add("port in drive", OP_PIN, 1, 0, 2, 1, 1);
    add("port in read", OP_RD, io_pkg::ADR_PORT_IN, 0, 2, 1, 1);
    add("tick sample 1", OP_WR, io_pkg::ADR_TICK_SAMPLE, 0, 0, 1, 0);
    add("sample reads 0", OP_RD, io_pkg::ADR_TICK_SAMPLE, 0, 0, 1, 0);
    add("tick read 1", OP_TICK, 0, 0, 0, 4, 0);
    add("tick gap", OP_WAIT, 0, 0, 0, 37, 0);
    add("tick sample 2", OP_WR, io_pkg::ADR_TICK_SAMPLE, 1, 0, 1, 0);
    add("tick difference", OP_TICK, 0, 1, 0, 4, 0);
    // Pin 1 stays out of the mask
    add("int mask write", OP_WR, io_pkg::ADR_INT_MASK, 16'h000d, 0, 1, 0);
    add("int pin 0 rise", OP_PIN, 0, 16'h0001, 0, 1, 0);
    add("int 0 arrives", OP_WINT, 0, 2, 48'h01, 4, 0);
    add("int pin 1 rise", OP_PIN, 0, 16'h0003, 0, 1, 0);
    add("int 1 settle", OP_WAIT, 0, 0, 0, 5, 0);
    add("int 1 masked", OP_RQ, 0, 0, 48'h01, 1, 0);
    add("int 0 clear", OP_WR, io_pkg::ADR_INT_FLAGS, 16'hfffe, 0, 1, 0);
    add("int 0 release", OP_WR, io_pkg::ADR_INT_FLAGS, 16'hffff, 0, 1, 0);
    add("int 0 cleared", OP_RQ, 0, 0, 0, 1, 0);
    add("int clear hold", OP_WAIT, 0, 0, 0, 10, 0);
    add("int 0 stays clear", OP_RQ, 0, 0, 0, 1, 0);
    add("int mask open", OP_WR, io_pkg::ADR_INT_MASK, 16'h000f, 0, 1, 0);
    add("int 1 pending", OP_RQ, 0, 0, 48'h02, 1, 0);
    add("int pins low", OP_PIN, 0, 16'h0000, 0, 1, 0);
    add("int clear all", OP_WR, io_pkg::ADR_INT_FLAGS, 16'h0000, 0, 1, 0);
    add("int release all", OP_WR, io_pkg::ADR_INT_FLAGS, 16'hffff, 0, 1, 0);
    add("timer mask", OP_WR, io_pkg::ADR_INT_MASK, 16'h0080, 0, 1, 0);
    add("timer reload lo", OP_WR, io_pkg::ADR_TIMER_L, 16'd25, 0, 1, 0);
    add("timer reload hi", OP_WR, io_pkg::ADR_TIMER_H, 16'd0, 0, 1, 0);
    add("timer first", OP_WINT, 0, 0, 48'h80, 40, 0);
    add("timer clear", OP_WR, io_pkg::ADR_INT_FLAGS, 16'hff7f, 0, 1, 0);
    add("timer release", OP_WR, io_pkg::ADR_INT_FLAGS, 16'hffff, 0, 1, 0);
    add("timer cleared", OP_RQ, 0, 0, 0, 1, 0);
    add("timer second", OP_WINT, 0, 1, 48'h80, 40, 0);
    add("timer period", OP_PERIOD, 0, 0, 48'd25, 1, 0);
    add("timer stop lo", OP_WR, io_pkg::ADR_TIMER_L, 16'd0, 0, 1, 0);
    add("timer stop hi", OP_WR, io_pkg::ADR_TIMER_H, 16'd0, 0, 1, 0);
  endtask

  task automatic run_step(input step_t s);
    io_pkg::word_t d;
    io_pkg::word_t w;
    logic [47:0] v;
    int n;
    bit found;
    d = s.data;
    if (s.rnd && (s.op == OP_WR || s.op == OP_PIN))
    begin
      get_rand(d);
      rand_val[s.exp[1:0]] = d;
    end
    case (s.op)
      OP_WR:
      begin
        drive(s.addr, 1'b1, d, 1'b0, 3'd0, '0, '0, s.name);
        if (s.addr == io_pkg::ADR_TICK_SAMPLE)
        begin
          @(negedge clk);
          sample_cyc[s.data[0]] = cyc;
        end
      end
      OP_RD:
        drive(s.addr, 1'b0, '0, 1'b1, 3'd0,
              s.rnd ? {32'd0, rand_val[s.exp[1:0]]} : s.exp, '0, s.name);
      OP_OUT:
        drive('0, 1'b0, '0, 1'b1, (s.addr == 0) ? 3'd2 : 3'd3,
              {32'd0, rand_val[s.exp[1:0]]}, '0, s.name);
      OP_PIN:
      begin
        drive('0, 1'b0, '0, 1'b0, 3'd0, '0, '0, s.name);
        if (s.addr == 0)
          ext_int <= d[3:0];
        else
          port_in <= d;
      end
      OP_WAIT:
      begin
        drive('0, 1'b0, '0, 1'b0, 3'd0, '0, '0, s.name);
        repeat (s.cycles - 1) @(posedge clk);
      end
      OP_RQ:
        drive('0, 1'b0, '0, 1'b1, 3'd1, s.exp, '0, s.name);
      OP_WINT:
      begin
        drive('0, 1'b0, '0, 1'b0, 3'd0, '0, '0, s.name);
        n = 0;
        found = 0;
        while (!found && n < s.cycles)
        begin
          @(negedge clk);
          n++;
          if ((int_rqst & s.exp[7:0]) == s.exp[7:0])
            found = 1;
        end
        if (found)
          rise_cyc[s.data[1:0]] = cyc;
        else
        begin
          drive('0, 1'b0, '0, 1'b0, 3'd0, s.exp, '0, s.name);
          missed <= 1'b1;
        end
      end
      OP_TICK:
      begin
        read_word(io_pkg::ADR_TICKSS_L, w);
        v[15:0] = w;
        read_word(io_pkg::ADR_TICKSS_H, w);
        v[31:16] = w;
        read_word(io_pkg::ADR_TICKSS_HH, w);
        v[47:32] = w;
        if (s.data == 0)
          tick_val = v;
        else
          drive('0, 1'b0, '0, 1'b1, 3'd4, sample_cyc[1] - sample_cyc[0],
                v - tick_val, s.name);
      end
      OP_PERIOD:
        drive('0, 1'b0, '0, 1'b1, 3'd4, s.exp, rise_cyc[1] - rise_cyc[0], s.name);
      default:
        $display("Unknown operation %0d in %0s", s.op, s.name);
    endcase
  endtask

  // Watchdog sized from the table
  initial
  begin
    wait (limit > 0);
    #(limit * 20);
    $display("Timeout after %0d cycles, the test sequence did not finish", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    resetq = 1'b0;
    io_addr = '0;
    io_wr = 1'b0;
    io_wdata = '0;
    ext_int = '0;
    port_in = '0;
    chk = 1'b0;
    chk_sel = '0;
    chk_exp = '0;
    chk_name = '0;
    measured = '0;
    missed = 1'b0;
    done = 1'b0;
    build_table();
    foreach (steps[i])
      limit += steps[i].cycles + 4;
    limit += 100;
    repeat (8) @(posedge clk);
    resetq <= 1'b1;
    foreach (steps[i])
      run_step(steps[i]);
    drive('0, 1'b0, '0, 1'b0, 3'd0, '0, '0, '0);
    done <= 1'b1;
    @(posedge clk);
    done <= 1'b0;
    @(posedge clk);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
common/io_pkg.sv
int_ctrl/edge_sync.sv
int_ctrl/int_ctrl.sv
timers/tick_counter.sv
timers/period_timer.sv
rtl/io_decode.sv
rtl/io_top.sv
test/io_checker.sv
test/tb_io_top.sv

//--- run.sh
#!/bin/bash
# Build and run the I/O block testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_io_top -o sim_io_top &&
./obj_dir/sim_io_top | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
